// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = host_io_tb
FILELIST   = filelist.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) logic/host_io_macros.svh
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+logic
logic/host_io_pkg.sv
logic/cmd_framer.sv
logic/input_regs.sv
logic/ps2_key_decoder.sv
logic/file_loader.sv
logic/host_io.sv
test/host_io_tb.sv

// File: logic/cmd_framer.sv
/*
 * Turns the host enable/strobe framing into one registered frame word.
 * Bus inputs are taken as synchronous to clk_sys.
 * Strobes must be at least 4 clk_sys cycles apart and only inside io_enable.
 */

`include "host_io_macros.svh"

module cmd_framer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  logic [`HIO_DATA_W-1:0] io_din,
	output host_io_pkg::io_frame_t frame
);

	// io_enable one cycle back, marks an open frame
	logic en_q;
	// the command word of this frame has been seen
	logic has_cmd;

	//////////////////////////////////////////////////
	// frame tracking
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			frame   <= '0;
			en_q    <= 1'b0;
			has_cmd <= 1'b0;
		end else begin
			en_q         <= io_enable;
			frame.strobe <= io_enable & io_strobe;
			// falling edge of enable closes the frame
			frame.done   <= en_q & ~io_enable;

			if (!io_enable) begin
				has_cmd <= 1'b0;
				// keep the command through the done cycle, then forget it
				if (!en_q) begin
					frame.cmd <= host_io_pkg::CMD_NONE;
				end
			end else if (io_strobe) begin
				frame.data <= io_din;
				if (!has_cmd) begin
					has_cmd     <= 1'b1;
					frame.first <= 1'b1;
					frame.cmd   <= host_io_pkg::cmd_e'(io_din[7:0]);
					frame.idx   <= '0;
				end else begin
					frame.first <= 1'b0;
					// index sticks at all ones on very long frames
					if (~&frame.idx) begin
						frame.idx <= frame.idx + 1'b1;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// host protocol: words only arrive inside an open frame
	a_strobe_in_frame: assert property (
		@(posedge clk_sys) disable iff (reset)
		io_strobe |-> io_enable
	);

endmodule

// File: logic/file_loader.sv
/*
 * File download path.
 * One write pulse per FILE_TX_DAT data word, no buffering, so the host
 * must honour io_wait. The address steps by 1 or 2 with the word mode.
 * FILE_INFO takes the extension from its first two data words only.
 */

`include "host_io_macros.svh"

module file_loader (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  host_io_pkg::io_frame_t        frame,
	output logic                          ioctl_download,
	output logic [7:0]                    ioctl_index,
	output logic                          ioctl_wr,
	output logic [`HIO_ADDR_W-1:0]        ioctl_addr,
	output logic [`HIO_IOCTL_DW-1:0]      ioctl_dout,
	output logic [31:0]                   ioctl_file_ext
);

	// next write address
	logic [`HIO_ADDR_W-1:0] addr;
	logic                   data_wr;
	logic                   tx_dat;

	assign data_wr = frame.strobe & ~frame.first;
	assign tx_dat  = data_wr & (frame.cmd == host_io_pkg::CMD_FILE_TX_DAT);

	//////////////////////////////////////////////////
	// download control
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			addr           <= '0;
		end else begin
			ioctl_wr <= tx_dat;
			if (data_wr) begin
				case (frame.cmd)
					host_io_pkg::CMD_FILE_INDEX: begin
						ioctl_index <= frame.data[7:0];
					end
					host_io_pkg::CMD_FILE_TX: begin
						if (frame.data[7:0] != 8'h00) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// leaves the size of the file on the address bus
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end
					host_io_pkg::CMD_FILE_TX_DAT: begin
						ioctl_addr <= addr;
						addr       <= addr + `HIO_ADDR_W'(`HIO_ADDR_STEP);
					end
					default: begin
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// payload
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (tx_dat) begin
			ioctl_dout <= frame.data[`HIO_IOCTL_DW-1:0];
		end
		if (data_wr && frame.cmd == host_io_pkg::CMD_FILE_INFO) begin
			// high half comes first
			if (frame.idx == 1) begin
				ioctl_file_ext[31:16] <= frame.data;
			end else if (frame.idx == 2) begin
				ioctl_file_ext[15:0] <= frame.data;
			end
		end
	end

	// strobes are spaced apart, so writes never merge
	a_wr_single: assert property (
		@(posedge clk_sys) disable iff (reset)
		ioctl_wr |=> !ioctl_wr
	);

endmodule

// File: logic/host_io.sv
/*
 * Host command port top level.
 * The host must hold off io_strobe while io_wait is high, nothing is buffered.
 * Only input_regs answers reads, the other blocks just listen to the frame.
 */

`include "host_io_macros.svh"

module host_io (
	input  logic                          clk_sys,
	input  logic                          reset,

	// host bus
	input  logic                          io_enable,
	input  logic                          io_strobe,
	input  logic [`HIO_DATA_W-1:0]        io_din,
	output logic [`HIO_DATA_W-1:0]        io_dout,
	output logic                          io_wait,

	// core controls
	output logic [1:0]                    buttons,
	output logic                          forced_scandoubler,
	output logic [31:0]                   joystick_0,
	output logic [31:0]                   joystick_1,
	output logic [31:0]                   status,
	input  logic [31:0]                   status_in,
	input  logic                          status_set,

	// keyboard
	output host_io_pkg::ps2_key_t         ps2_key,

	// file download
	output logic                          ioctl_download,
	output logic [7:0]                    ioctl_index,
	output logic                          ioctl_wr,
	output logic [`HIO_ADDR_W-1:0]        ioctl_addr,
	output logic [`HIO_IOCTL_DW-1:0]      ioctl_dout,
	output logic [31:0]                   ioctl_file_ext,
	input  logic                          ioctl_wait
);

	host_io_pkg::io_frame_t frame;

	// back-pressure goes straight through to the host
	assign io_wait = ioctl_wait;

	cmd_framer u_framer (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.frame     (frame)
	);

	input_regs u_regs (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.frame              (frame),
		.status_in          (status_in),
		.status_set         (status_set),
		.cfg_buttons        (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.io_dout            (io_dout)
	);

	ps2_key_decoder u_kbd (
		.clk_sys (clk_sys),
		.reset   (reset),
		.frame   (frame),
		.ps2_key (ps2_key)
	);

	file_loader u_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.frame          (frame),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

endmodule

// File: logic/host_io_macros.svh
/*
 * Widths and constants shared by the host command port.
 * HIO_WIDE picks the download word mode. 0 gives byte data with an
 * address step of 1, and 1 gives 16-bit data with a step of 2.
 */

`ifndef HOST_IO_MACROS_SVH
`define HOST_IO_MACROS_SVH

//////////////////////////////////////////////////
// host bus
//////////////////////////////////////////////////

// one word on the host bus
`define HIO_DATA_W 16

// word index inside a frame, saturates at all ones
`define HIO_CNT_W 10

//////////////////////////////////////////////////
// file download
//////////////////////////////////////////////////

// word mode of the download path
`define HIO_WIDE 0

`define HIO_IOCTL_DW ((`HIO_WIDE) ? 16 : 8)
`define HIO_ADDR_STEP ((`HIO_WIDE) ? 2 : 1)
`define HIO_ADDR_W 27

//////////////////////////////////////////////////
// keyboard scan codes
//////////////////////////////////////////////////

// extended prefix
`define HIO_KEY_EXT 8'he0
// break (release) prefix
`define HIO_KEY_BREAK 8'hf0
// high byte marking a word to ignore
`define HIO_KEY_SKIP 8'hff

`endif

// File: logic/host_io_pkg.sv
/*
 * Types shared by the host command port blocks.
 * Command opcodes only look at the low byte of the command word.
 * CMD_NONE is what the framer holds between frames.
 */

`include "host_io_macros.svh"

package host_io_pkg;

	// command opcodes, first word of a frame
	typedef enum logic [7:0] {
		CMD_NONE        = 8'h00,
		CMD_CFG         = 8'h01,
		CMD_JOY0        = 8'h02,
		CMD_JOY1        = 8'h03,
		CMD_KBD         = 8'h05,
		CMD_STATUS      = 8'h1e,
		CMD_STATUS_REQ  = 8'h29,
		CMD_FILE_TX     = 8'h53,
		CMD_FILE_TX_DAT = 8'h54,
		CMD_FILE_INDEX  = 8'h55,
		CMD_FILE_INFO   = 8'h56
	} cmd_e;

	// one registered word of a host frame, as seen by every handler
	typedef struct packed {
		cmd_e                   cmd;
		logic [`HIO_CNT_W-1:0]  idx;
		logic [`HIO_DATA_W-1:0] data;
		// word valid for one cycle
		logic                   strobe;
		// this word is the command word
		logic                   first;
		// one cycle after the frame has closed
		logic                   done;
	} io_frame_t;

	// keyboard event, toggle flips on every new event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

endpackage

// File: logic/input_regs.sv
/*
 * Config byte, joysticks, status word and the status-set request.
 * Only this block drives io_dout. It answers CMD_STATUS_REQ and is
 * zero for every other command and between frames.
 * status_set is taken as synchronous to clk_sys.
 */

`include "host_io_macros.svh"

module input_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  host_io_pkg::io_frame_t frame,
	input  logic [31:0]            status_in,
	input  logic                   status_set,
	output logic [1:0]             cfg_buttons,
	output logic                   forced_scandoubler,
	output logic [31:0]            joystick_0,
	output logic [31:0]            joystick_1,
	output logic [31:0]            status,
	output logic [`HIO_DATA_W-1:0] io_dout
);

	logic [7:0]  cfg;
	logic        status_set_q;
	// counts core requests, host compares it with its last read
	logic [3:0]  req_cnt;
	logic [31:0] status_req;
	// data word of the current frame
	logic        data_wr;

	assign cfg_buttons        = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign data_wr            = frame.strobe & ~frame.first;

	//////////////////////////////////////////////////
	// host writes
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (data_wr) begin
			case (frame.cmd)
				host_io_pkg::CMD_CFG: begin
					cfg <= frame.data[7:0];
				end
				host_io_pkg::CMD_JOY0: begin
					if (frame.idx == 1) begin
						joystick_0[15:0] <= frame.data;
					end else begin
						joystick_0[31:16] <= frame.data;
					end
				end
				host_io_pkg::CMD_JOY1: begin
					if (frame.idx == 1) begin
						joystick_1[15:0] <= frame.data;
					end else begin
						joystick_1[31:16] <= frame.data;
					end
				end
				host_io_pkg::CMD_STATUS: begin
					// words past the second are ignored
					if (frame.idx == 1) begin
						status[15:0] <= frame.data;
					end else if (frame.idx == 2) begin
						status[31:16] <= frame.data;
					end
				end
				default: begin
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// core status-set request
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_q <= 1'b0;
			req_cnt      <= '0;
			status_req   <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set & ~status_set_q) begin
				req_cnt    <= req_cnt + 1'b1;
				status_req <= status_in;
			end
		end
	end

	//////////////////////////////////////////////////
	// readback
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout <= '0;
		end else if (frame.done) begin
			io_dout <= '0;
		end else if (frame.strobe) begin
			io_dout <= '0;
			if (frame.cmd == host_io_pkg::CMD_STATUS_REQ) begin
				if (frame.first) begin
					io_dout <= {4'ha, 8'h00, req_cnt};
				end else if (frame.idx == 1) begin
					io_dout <= status_req[15:0];
				end else if (frame.idx == 2) begin
					io_dout <= status_req[31:16];
				end
			end
		end
	end

	// bus stays quiet outside status request frames, so also after done
	a_dout_idle: assert property (
		@(posedge clk_sys) disable iff (reset)
		(frame.cmd != host_io_pkg::CMD_STATUS_REQ) |-> (io_dout == '0)
	);

endmodule

// File: logic/ps2_key_decoder.sv
/*
 * PS/2 keyboard alternative interface.
 * Up to four scan bytes per frame are kept, older ones fall out.
 * A word with FF in the high byte drops the whole frame.
 */

`include "host_io_macros.svh"

module ps2_key_decoder (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  host_io_pkg::io_frame_t frame,
	output host_io_pkg::ps2_key_t  ps2_key
);

	// newest byte in the low end
	logic [31:0]            raw;
	logic                   skip;
	logic                   kbd_frame;
	host_io_pkg::ps2_key_t  key_next;

	assign kbd_frame = (frame.cmd == host_io_pkg::CMD_KBD);

	//////////////////////////////////////////////////
	// byte collection
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (frame.strobe && kbd_frame) begin
			if (frame.first) begin
				raw <= '0;
			end else if (frame.data[15:8] != `HIO_KEY_SKIP && !skip) begin
				raw <= {raw[23:0], frame.data[7:0]};
			end
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			skip <= 1'b0;
		end else if (frame.done || (frame.strobe && frame.first)) begin
			skip <= 1'b0;
		end else if (frame.strobe && kbd_frame && frame.data[15:8] == `HIO_KEY_SKIP) begin
			skip <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////

	always_comb begin
		key_next.toggle   = ~ps2_key.toggle;
		key_next.pressed  = (raw[15:8] != `HIO_KEY_BREAK);
		// prefix sits one byte further back on a release
		key_next.extended = key_next.pressed ? (raw[15:8] == `HIO_KEY_EXT)
		                                     : (raw[23:16] == `HIO_KEY_EXT);
		key_next.code     = raw[7:0];

		// print screen break and pause do not follow the normal layout
		case (raw)
			32'h7ce0f012: begin
				key_next.pressed  = 1'b0;
				key_next.extended = 1'b1;
				key_next.code     = 8'h7c;
			end
			32'hf014f077: begin
				key_next.pressed  = 1'b1;
				key_next.extended = 1'b1;
				key_next.code     = 8'h77;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ps2_key <= '0;
		end else if (frame.done && kbd_frame && !skip) begin
			ps2_key <= key_next;
		end
	end

endmodule

// File: test/host_io_tb.sv
/*
 * Testbench for the host command port.
 * Stimulus comes from an LFSR with a fixed seed and is checked against a
 * model kept here. Download word mode follows the macros header.
 */

`include "host_io_macros.svh"

module host_io_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 100;

	logic                         clk_sys = 1'b0;
	logic                         reset;
	logic                         io_enable;
	logic                         io_strobe;
	logic [`HIO_DATA_W-1:0]       io_din;
	logic [`HIO_DATA_W-1:0]       io_dout;
	logic                         io_wait;
	logic [1:0]                   buttons;
	logic                         forced_scandoubler;
	logic [31:0]                  joystick_0;
	logic [31:0]                  joystick_1;
	logic [31:0]                  status;
	logic [31:0]                  status_in;
	logic                         status_set;
	host_io_pkg::ps2_key_t        ps2_key;
	logic                         ioctl_download;
	logic [7:0]                   ioctl_index;
	logic                         ioctl_wr;
	logic [`HIO_ADDR_W-1:0]       ioctl_addr;
	logic [`HIO_IOCTL_DW-1:0]     ioctl_dout;
	logic [31:0]                  ioctl_file_ext;
	logic                         ioctl_wait;

	logic [31:0]                  lfsr = 32'hfa1bfac2;
	int                           errors = 0;
	int                           wr_errors = 0;
	int                           tests_run = 0;
	int                           tests_failed = 0;
	int                           test_base = 0;
	// back-pressure noise on ioctl_wait during data frames
	logic                         bp_on = 1'b0;
	logic                         wr_prev = 1'b0;
	logic [15:0]                  tx_words [$];
	logic [15:0]                  rx_words [$];
	logic [`HIO_ADDR_W-1:0]       wr_addr [$];
	logic [`HIO_IOCTL_DW-1:0]     wr_data [$];

	// model state
	logic [7:0]                   cfg_m = '0;
	logic [31:0]                  joy_m [2] = '{32'h0, 32'h0};
	logic [31:0]                  status_m = '0;
	logic [3:0]                   cnt_m = '0;
	logic [31:0]                  cap_m = '0;
	host_io_pkg::ps2_key_t        key_m = '0;

	host_io DUT (.*);

	always #50 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic next_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 32'h80200003;
		end
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	function automatic int total_errors();
		return errors + wr_errors;
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		$display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
		errors++;
	endtask

	task automatic give_up(input string why);
		$display("timeout: %s", why);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (total_errors() == test_base) begin
			$display("%s: pass", name);
		end else begin
			$display("%s: fail, %0d errors", name, total_errors() - test_base);
			tests_failed++;
		end
		test_base = total_errors();
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk_sys);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				give_up("io_wait stayed high");
			end
		end while (io_wait);
	endtask

	// one word, readback taken 3 cycles after its strobe
	task automatic send_word(input logic [15:0] word);
		logic [1:0] hold;
		hold = 2'(rand_bits(2));
		fork
			begin
				if (bp_on && hold != 0) begin
					ioctl_wait = 1'b1;
					repeat (hold) @(negedge clk_sys);
					ioctl_wait = 1'b0;
				end
			end
			wait_ready();
		join
		@(negedge clk_sys);
		io_din    = word;
		io_strobe = 1'b1;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		repeat (2) @(negedge clk_sys);
		rx_words.push_back(io_dout);
	endtask

	task automatic send_frame();
		rx_words.delete();
		@(negedge clk_sys);
		io_enable = 1'b1;
		foreach (tx_words[k]) begin
			send_word(tx_words[k]);
		end
		@(negedge clk_sys);
		io_enable = 1'b0;
		// done, readback clear and key update all land in this gap
		repeat (4) @(negedge clk_sys);
	endtask

	// write pulses as the core would see them
	always @(negedge clk_sys) begin
		if (ioctl_wr) begin
			if (wr_prev) begin
				$display("[ERROR] %0t ioctl_wr high two cycles in a row", $time);
				wr_errors++;
			end
			wr_addr.push_back(ioctl_addr);
			wr_data.push_back(ioctl_dout);
		end
		wr_prev = ioctl_wr;
	end

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic reset_values();
		if ({ioctl_wr, ioctl_download, ps2_key, io_dout, status} !== '0) begin
			report_mismatch("outputs after reset",
				64'({ioctl_wr, ioctl_download, ps2_key, io_dout, status}), 64'(0));
		end
		repeat (16) begin
			@(negedge clk_sys);
			ioctl_wait = next_bit();
			@(posedge clk_sys);
			if (io_wait !== ioctl_wait) begin
				report_mismatch("io_wait", 64'(io_wait), 64'(ioctl_wait));
			end
		end
		@(negedge clk_sys);
		ioctl_wait = 1'b0;
		end_test("reset and io_wait");
	endtask

	task automatic config_and_joysticks();
		int          sel;
		int          n;
		logic [15:0] w;
		repeat (12) begin
			sel = int'(rand_bits(2));
			tx_words.delete();
			if (sel == 0 || sel == 3) begin
				w = 16'(rand_bits(16));
				tx_words.push_back(16'h0001);
				tx_words.push_back(w);
				cfg_m = w[7:0];
			end else begin
				tx_words.push_back(sel == 1 ? 16'h0002 : 16'h0003);
				n = 1 + int'(rand_bits(2));
				for (int k = 1; k <= n; k++) begin
					w = 16'(rand_bits(16));
					tx_words.push_back(w);
					// first data word is the low half, the rest the high half
					if (k == 1) begin
						joy_m[sel-1][15:0] = w;
					end else begin
						joy_m[sel-1][31:16] = w;
					end
				end
			end
			send_frame();
			if ({buttons, forced_scandoubler} !== {cfg_m[1:0], cfg_m[4]}) begin
				report_mismatch("config outputs", 64'({buttons, forced_scandoubler}),
					64'({cfg_m[1:0], cfg_m[4]}));
			end
			if ({joystick_1, joystick_0} !== {joy_m[1], joy_m[0]}) begin
				report_mismatch("joysticks", {joystick_1, joystick_0}, {joy_m[1], joy_m[0]});
			end
		end
		end_test("config and joysticks");
	endtask

	task automatic status_words();
		int          n;
		logic [15:0] w;
		repeat (10) begin
			tx_words.delete();
			if (next_bit()) begin
				tx_words.push_back(16'h001e);
				n = 1 + int'(rand_bits(2)) % 3;
				for (int k = 1; k <= n; k++) begin
					w = 16'(rand_bits(16));
					tx_words.push_back(w);
					if (k == 1) begin
						status_m[15:0] = w;
					end else if (k == 2) begin
						status_m[31:16] = w;
					end
				end
				send_frame();
			end else begin
				n = 1 + int'(rand_bits(2));
				repeat (n) begin
					@(negedge clk_sys);
					status_in  = rand_bits(32);
					status_set = 1'b1;
					@(negedge clk_sys);
					status_set = 1'b0;
					cnt_m      = cnt_m + 4'd1;
					cap_m      = status_in;
				end
				tx_words.push_back(16'h0029);
				tx_words.push_back(16'(rand_bits(16)));
				tx_words.push_back(16'(rand_bits(16)));
				send_frame();
				if ({rx_words[0], rx_words[1], rx_words[2]} !==
					{4'ha, 8'h00, cnt_m, cap_m[15:0], cap_m[31:16]}) begin
					report_mismatch("status request readback",
						64'({rx_words[0], rx_words[1], rx_words[2]}),
						64'({4'ha, 8'h00, cnt_m, cap_m[15:0], cap_m[31:16]}));
				end
			end
			if (status !== status_m) begin
				report_mismatch("status", 64'(status), 64'(status_m));
			end
			if (io_dout !== '0) begin
				report_mismatch("io_dout after frame", 64'(io_dout), 64'(0));
			end
		end
		end_test("status and readback");
	endtask

	task automatic keyboard_events();
		int          kind;
		int          nb;
		int          pos;
		logic        skip;
		logic [7:0]  code;
		logic [63:0] seq;
		// pressed, extended, code
		logic [9:0]  exp;
		repeat (16) begin
			kind = int'(rand_bits(3));
			code = 8'(rand_bits(7));
			case (kind)
				1: begin
					seq = {48'h0, 8'hf0, code};
					nb  = 2;
					exp = {2'b00, code};
				end
				2: begin
					seq = {48'h0, 8'he0, code};
					nb  = 2;
					exp = {2'b11, code};
				end
				3: begin
					seq = {40'h0, 8'he0, 8'hf0, code};
					nb  = 3;
					exp = {2'b01, code};
				end
				// print screen make and break, then pause
				4: begin
					seq = 64'h00000000_e012e07c;
					nb  = 4;
					exp = {2'b11, 8'h7c};
				end
				5: begin
					seq = 64'h0000e0f0_7ce0f012;
					nb  = 6;
					exp = {2'b01, 8'h7c};
				end
				6: begin
					seq = 64'he11477e1_f014f077;
					nb  = 8;
					exp = {2'b11, 8'h77};
				end
				default: begin
					seq = {56'h0, code};
					nb  = 1;
					exp = {2'b10, code};
				end
			endcase
			tx_words.delete();
			tx_words.push_back(16'h0005);
			for (int k = nb - 1; k >= 0; k--) begin
				tx_words.push_back({1'b0, 7'(rand_bits(7)), seq[8*k +: 8]});
			end
			skip = (rand_bits(2) == 0);
			if (skip) begin
				pos = 1 + int'(rand_bits(3)) % nb;
				tx_words.insert(pos, {8'hff, 8'(rand_bits(8))});
			end else begin
				key_m = {~key_m.toggle, exp};
			end
			send_frame();
			if (ps2_key !== key_m) begin
				report_mismatch(skip ? "ps2_key after skipped frame" : "ps2_key",
					64'(ps2_key), 64'(key_m));
			end
		end
		end_test("keyboard");
	endtask

	task automatic file_download();
		int          n;
		int          base;
		int          cycles;
		logic [7:0]  idx_v;
		logic [31:0] ext;
		logic [15:0] data_q [$];
		repeat (2) begin
			idx_v = 8'(rand_bits(8));
			ext   = rand_bits(32);
			tx_words.delete();
			tx_words.push_back(16'h0055);
			tx_words.push_back({8'h00, idx_v});
			send_frame();
			tx_words.delete();
			tx_words.push_back(16'h0056);
			tx_words.push_back(ext[31:16]);
			tx_words.push_back(ext[15:0]);
			send_frame();
			tx_words.delete();
			tx_words.push_back(16'h0053);
			tx_words.push_back({8'h00, 8'(rand_bits(7)) | 8'h01});
			send_frame();
			if (ioctl_download !== 1'b1) begin
				report_mismatch("ioctl_download at start", 64'(ioctl_download), 64'(1));
			end

			n    = 1 + int'(rand_bits(4));
			base = wr_addr.size();
			data_q.delete();
			tx_words.delete();
			tx_words.push_back(16'h0054);
			repeat (n) begin
				data_q.push_back(16'(rand_bits(16)));
				tx_words.push_back(data_q[$]);
			end
			bp_on = 1'b1;
			send_frame();
			bp_on = 1'b0;
			cycles = 0;
			while (wr_addr.size() < base + n) begin
				cycles++;
				if (cycles > WAIT_LIMIT) begin
					give_up("download write pulses missing");
				end
				@(negedge clk_sys);
			end
			if (wr_addr.size() != base + n) begin
				report_mismatch("write pulse count", 64'(wr_addr.size() - base), 64'(n));
			end
			for (int k = 0; k < n; k++) begin
				if ({wr_addr[base+k], wr_data[base+k]} !==
					{`HIO_ADDR_W'(k * `HIO_ADDR_STEP), data_q[k][`HIO_IOCTL_DW-1:0]}) begin
					report_mismatch("write address and data",
						64'({wr_addr[base+k], wr_data[base+k]}),
						64'({`HIO_ADDR_W'(k * `HIO_ADDR_STEP), data_q[k][`HIO_IOCTL_DW-1:0]}));
				end
			end

			tx_words.delete();
			tx_words.push_back(16'h0053);
			tx_words.push_back({8'(rand_bits(8)), 8'h00});
			send_frame();
			// final address is the size of the file
			if ({ioctl_download, ioctl_index, ioctl_addr} !==
				{1'b0, idx_v, `HIO_ADDR_W'(n * `HIO_ADDR_STEP)}) begin
				report_mismatch("download end state",
					64'({ioctl_download, ioctl_index, ioctl_addr}),
					64'({1'b0, idx_v, `HIO_ADDR_W'(n * `HIO_ADDR_STEP)}));
			end
			if (ioctl_file_ext !== ext) begin
				report_mismatch("ioctl_file_ext", 64'(ioctl_file_ext), 64'(ext));
			end
		end
		end_test("file download");
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		reset      = 1'b1;
		io_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		reset_values();
		config_and_joysticks();
		status_words();
		keyboard_events();
		file_download();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors());
		if (total_errors() == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
